// File: mips_alu_cluster.f
+incdir+verilog
verilog/mips_isa_pkg.sv
verilog/alu_result_pkg.sv
verilog/add_sub_logic.sv
verilog/instr_decode.sv
verilog/alu_lane.sv
verilog/result_collect.sv
verilog/mips_alu_cluster.sv
verification/mips_alu_cluster_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SIMD ALU cluster testbench with Verilator.
set -u -o pipefail

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=mips_alu_cluster_tb

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f mips_alu_cluster.f --top-module "$TOP" -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: verification/alu_cluster_vectors.txt
# instr a0 b0 a1 b1 a2 b2 a3 b3 r0 r1 r2 r3 mask illegal, all hex
# mask bit i is the branch taken bit of lane i
# r-type addu subu and or xor
00221821 00000001 00000002 ffffffff 00000001 7fffffff 00000001 12345678 11111111 00000003 00000000 80000000 23456789 0 0
00221823 00000005 00000003 00000000 00000001 80000000 00000001 deadbeef deadbeef 00000002 ffffffff 7fffffff 00000000 0 0
00221824 ffff0000 0f0f0f0f 12345678 ffffffff aaaaaaaa 55555555 deadbeef 0000ffff 0f0f0000 12345678 00000000 0000beef 0 0
00221825 ffff0000 0f0f0f0f 00000000 00000000 aaaaaaaa 55555555 12340000 00005678 ffff0f0f 00000000 ffffffff 12345678 0 0
00221826 ffff0000 0f0f0f0f aaaaaaaa ffffffff 12345678 12345678 deadbeef 00000000 f0f00f0f 55555555 00000000 deadbeef 0 0
# addiu and load/store address sums, sign-extended immediate
24220010 00000000 ffffffff fffffff0 12345678 7ffffff8 00000000 12345678 deadbeef 00000010 00000000 80000008 12345688 0 0
2422fffc 00000000 11111111 00000004 22222222 00001000 33333333 80000000 44444444 fffffffc 00000000 00000ffc 7ffffffc 0 0
8c220008 10000000 aaaaaaaa fffffff8 bbbbbbbb 00000100 cccccccc 7ffffffc dddddddd 10000008 00000000 00000108 80000004 0 0
ac22fff0 10000010 01010101 00000000 02020202 00000020 03030303 ffffffff 04040404 10000000 fffffff0 00000010 ffffffef 0 0
80228000 00000000 ffffffff 00008000 ffffffff 00010000 ffffffff 12345678 ffffffff ffff8000 00000000 00008000 1233d678 0 0
90220004 00000000 00000000 fffffffc 00000000 00001000 00000000 0000fffc 00000000 00000004 00000000 00001004 00010000 0 0
a4227fff 00000000 80000000 00000001 80000000 ffff8001 80000000 7fff8001 80000000 00007fff 00008000 00000000 80000000 0 0
# andi ori xori, zero-extended immediate
3022ff0f ffffffff 00000000 12345678 ffffffff 0000f0f0 0000ffff 00000000 ffffffff 0000ff0f 00005608 0000f000 00000000 0 0
34228001 00000000 ffffffff ffff0000 00000000 12340000 11111111 00007ffe ffffffff 00008001 ffff8001 12348001 0000ffff 0 0
3822ffff 00000000 12345678 ffffffff 12345678 1234abcd 00000000 0000ffff ffff0000 0000ffff ffff0000 12345432 00000000 0 0
# branches beq bne blez bgtz
10220010 00000005 00000005 00000005 00000006 ffffffff ffffffff 00000000 00000001 00000000 00000000 00000000 00000000 5 0
14220010 00000005 00000005 00000005 00000006 ffffffff ffffffff 00000000 00000001 00000000 00000000 00000000 00000000 a 0
18220010 80000000 00000000 00000000 12345678 00000001 00000001 ffffffff ffffffff 00000000 00000000 00000000 00000000 b 0
1c220010 80000000 00000000 00000000 12345678 00000001 00000001 ffffffff ffffffff 00000000 00000000 00000000 00000000 4 0
1c220010 7fffffff 00000000 00000001 00000001 00000000 00000000 80000001 80000001 00000000 00000000 00000000 00000000 3 0
18220010 7fffffff 00000000 00000001 00000001 00000000 00000000 80000001 80000001 00000000 00000000 00000000 00000000 c 0
10220010 11111111 11111111 00000000 00000000 80000000 80000000 7fffffff 7fffffff 00000000 00000000 00000000 00000000 f 0
14220010 11111111 11111111 00000000 00000000 80000000 80000000 7fffffff 7fffffff 00000000 00000000 00000000 00000000 0 0
# illegal functs and opcodes
00221820 00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008 00000000 00000000 00000000 00000000 0 1
00221800 ffffffff ffffffff 12345678 12345678 80000000 00000001 00000000 00000000 00000000 00000000 00000000 00000000 0 1
08000100 00000001 00000001 ffffffff 00000000 00000000 00000000 7fffffff 7fffffff 00000000 00000000 00000000 00000000 0 1
3c021234 deadbeef 00000001 00000002 00000002 80000000 7fffffff 00000010 00000020 00000000 00000000 00000000 00000000 0 1
fc221234 00000000 00000000 00000001 00000001 ffffffff ffffffff 12345678 87654321 00000000 00000000 00000000 00000000 0 1
20220005 00000005 00000005 fffffffb 00000000 00000100 00000200 7fffffff 00000001 00000000 00000000 00000000 00000000 0 1
# back to normal work after illegal words
00221821 00000010 00000020 fffffffe 00000003 80000000 80000000 0000ffff 00000001 00000030 00000001 00000000 00010000 0 0

// File: verification/mips_alu_cluster_tb.sv
`timescale 1ns/1ps
`include "mips_alu_consts.svh"

module mips_alu_cluster_tb;

    localparam int LANES          = `ALU_NUM_LANES;
    localparam int W              = `ALU_WORD_W;
    localparam int TIMEOUT_CYCLES = 200;

    // dut ports.
    logic                              clk = 1'b0;
    logic                              rst;
    logic                              instr_valid;
    logic [31:0]                       instr;
    logic [LANES*W-1:0]                op_a;
    logic [LANES*W-1:0]                op_b;
    logic                              result_valid;
    logic [LANES*W-1:0]                result;
    alu_result_pkg::lane_mask_t        branch_taken;
    logic                              illegal;

    // expectations, one entry per vector except words (one per lane).
    alu_result_pkg::word_t      exp_word_q[$];
    alu_result_pkg::lane_mask_t exp_mask_q[$];
    logic                       exp_ill_q[$];
    int                         exp_due_q[$];
    int                         exp_idx_q[$];

    // rising edges seen so far.
    int cycle_cnt = 0;
    int checked   = 0;

    mips_alu_cluster DUT (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .op_a         (op_a),
        .op_b         (op_b),
        .result_valid (result_valid),
        .result       (result),
        .branch_taken (branch_taken),
        .illegal      (illegal)
    );

    // 8 ns period.
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ========================================
    // failure and compare tasks.
    // ========================================
    task automatic halt_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_word(input string name, input alu_result_pkg::word_t expected,
                                input alu_result_pkg::word_t actual);
        if (actual !== expected) begin
            halt_run($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic compare_mask(input string name, input alu_result_pkg::lane_mask_t expected,
                                input alu_result_pkg::lane_mask_t actual);
        if (actual !== expected) begin
            halt_run($sformatf("Mismatch %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic compare_illegal(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            halt_run($sformatf("Mismatch %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // ========================================
    // result monitor.
    // ========================================
    // outputs move on the rising edge, so look at them mid-cycle.
    always @(negedge clk) begin : check_results
        int                    idx;
        int                    due;
        alu_result_pkg::word_t exp_w;
        if (cycle_cnt > 0) begin
            if (result_valid === 1'b1) begin
                if (exp_due_q.size() == 0) begin
                    halt_run("result_valid went high with no instruction in flight");
                end else begin
                    idx = exp_idx_q.pop_front();
                    due = exp_due_q.pop_front();
                    if (due != cycle_cnt) begin
                        halt_run($sformatf("vector %0d result came at edge %0d, not at edge %0d",
                                           idx, cycle_cnt, due));
                    end
                    for (int i = 0; i < LANES; i++) begin
                        exp_w = exp_word_q.pop_front();
                        compare_word($sformatf("vector %0d lane %0d result", idx, i),
                                     exp_w, result[i*W +: W]);
                    end
                    compare_mask($sformatf("vector %0d taken mask", idx),
                                 exp_mask_q.pop_front(), branch_taken);
                    compare_illegal($sformatf("vector %0d illegal", idx),
                                    exp_ill_q.pop_front(), illegal);
                    checked = checked + 1;
                end
            end else if (result_valid !== 1'b0) begin
                halt_run("result_valid is unknown");
            end else if (illegal !== 1'b0) begin
                halt_run("illegal is high while result_valid is low");
            end else if (exp_due_q.size() != 0 && exp_due_q[0] < cycle_cnt) begin
                halt_run($sformatf("timeout: no result for vector %0d by edge %0d",
                                   exp_idx_q[0], exp_due_q[0]));
            end
        end
    end

    // ========================================
    // vector driver.
    // ========================================
    initial begin : drive_vectors
        int                         fd;
        int                         n;
        int                         idle;
        int                         vec_idx;
        int                         wait_cnt;
        string                      line;
        logic [31:0]                v_instr;
        logic [31:0]                a0, a1, a2, a3;
        logic [31:0]                b0, b1, b2, b3;
        alu_result_pkg::word_t      r0, r1, r2, r3;
        alu_result_pkg::lane_mask_t v_mask;
        logic                       v_ill;

        void'($urandom(32'hd9cf595b));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        op_a        = '0;
        op_b        = '0;
        vec_idx     = 0;

        // hold reset for 16 cycles.
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;

        fd = $fopen("verification/alu_cluster_vectors.txt", "r");
        if (fd == 0) begin
            halt_run("could not open verification/alu_cluster_vectors.txt");
        end

        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // skip blank and comment lines.
            if (n > 0 && line.len() > 1 && line[0] != 8'h23) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            v_instr, a0, b0, a1, b1, a2, b2, a3, b3,
                            r0, r1, r2, r3, v_mask, v_ill);
                if (n != 15) begin
                    halt_run($sformatf("malformed vector line: %s", line));
                end
                // some vectors get a short gap, the rest go back to back.
                idle = ((($urandom % 3) == 0)) ? int'($urandom % 4) : 0;
                repeat (idle) begin
                    @(posedge clk);
                    #1 instr_valid = 1'b0;
                end
                @(posedge clk);
                #1;
                instr_valid = 1'b1;
                instr       = v_instr;
                op_a        = {a3, a2, a1, a0};
                op_b        = {b3, b2, b1, b0};
                exp_word_q.push_back(r0);
                exp_word_q.push_back(r1);
                exp_word_q.push_back(r2);
                exp_word_q.push_back(r3);
                exp_mask_q.push_back(v_mask);
                exp_ill_q.push_back(v_ill);
                // result strobe on the third edge from here.
                exp_due_q.push_back(cycle_cnt + `ALU_LATENCY);
                exp_idx_q.push_back(vec_idx);
                vec_idx = vec_idx + 1;
            end
        end
        $fclose(fd);

        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr       = '0;

        // drain the pipeline.
        wait_cnt = 0;
        while (exp_due_q.size() != 0 && wait_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            wait_cnt = wait_cnt + 1;
        end

        if (exp_due_q.size() != 0 || vec_idx == 0) begin
            halt_run($sformatf("run ended with %0d results outstanding after %0d vectors",
                               exp_due_q.size(), vec_idx));
        end else begin
            $display("%0d vectors checked", checked);
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: verilog/mips_alu_cluster.sv
`timescale 1ns/1ps
`include "mips_alu_consts.svh"

module mips_alu_cluster #(
    parameter int NUM_LANES = `ALU_NUM_LANES
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              instr_valid,
    input  logic [31:0]                       instr,
    input  logic [NUM_LANES*`ALU_WORD_W-1:0]  op_a,
    input  logic [NUM_LANES*`ALU_WORD_W-1:0]  op_b,
    output logic                              result_valid,
    output logic [NUM_LANES*`ALU_WORD_W-1:0]  result,
    output logic [NUM_LANES-1:0]              branch_taken,
    output logic                              illegal
);

    localparam int W  = `ALU_WORD_W;
    localparam int FW = $bits(alu_result_pkg::branch_flags_t);

    // decoder to lanes.
    logic                       dec_valid;
    mips_isa_pkg::opcode_t      dec_opcode;
    mips_isa_pkg::funct_t       dec_funct;
    logic [NUM_LANES*W-1:0]     dec_op1;
    logic [NUM_LANES*W-1:0]     dec_op2;
    // decoder to collector, already aligned.
    mips_isa_pkg::branch_kind_t dec_kind;
    logic                       dec_illegal;
    // lanes to collector.
    logic [NUM_LANES-1:0]       ln_valid;
    logic [NUM_LANES*W-1:0]     ln_word;
    logic [NUM_LANES*FW-1:0]    ln_flags;

    instr_decode #(.NUM_LANES(NUM_LANES)) u_decode (
        .clk (clk), .rst (rst), .instr_valid (instr_valid), .instr (instr),
        .op_a (op_a), .op_b (op_b), .lane_valid (dec_valid), .opcode (dec_opcode),
        .funct (dec_funct), .lane_op1 (dec_op1), .lane_op2 (dec_op2),
        .branch_kind (dec_kind), .illegal (dec_illegal)
    );

    // ========================================
    // lanes.
    // ========================================
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        alu_lane u_lane (
            .clk (clk), .rst (rst), .in_valid (dec_valid),
            .opcode (dec_opcode), .funct (dec_funct),
            .op1 (dec_op1[i*W +: W]), .op2 (dec_op2[i*W +: W]),
            .out_valid (ln_valid[i]), .out_word (ln_word[i*W +: W]),
            .out_flags (ln_flags[i*FW +: FW])
        );
    end

    result_collect #(.NUM_LANES(NUM_LANES)) u_collect (
        .clk (clk), .rst (rst), .lane_valid (ln_valid), .lane_word (ln_word),
        .lane_flags (ln_flags), .branch_kind (dec_kind), .illegal_in (dec_illegal),
        .result_valid (result_valid), .result (result),
        .branch_taken (branch_taken), .illegal (illegal)
    );

endmodule

// File: verilog/result_collect.sv
`timescale 1ns/1ps
`include "mips_alu_consts.svh"

module result_collect #(
    parameter int NUM_LANES = `ALU_NUM_LANES
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [NUM_LANES-1:0]              lane_valid,
    input  logic [NUM_LANES*`ALU_WORD_W-1:0]  lane_word,
    input  logic [NUM_LANES*4-1:0]            lane_flags,
    input  mips_isa_pkg::branch_kind_t        branch_kind,
    input  logic                              illegal_in,
    output logic                              result_valid,
    output logic [NUM_LANES*`ALU_WORD_W-1:0]  result,
    output logic [NUM_LANES-1:0]              branch_taken,
    output logic                              illegal
);

    localparam int FW = $bits(alu_result_pkg::branch_flags_t);

    // lanes move in lock step, any bit stands for all.
    logic                             any_valid;
    logic [NUM_LANES-1:0]             taken;
    logic [NUM_LANES*`ALU_WORD_W-1:0] packed_word;

    assign any_valid = |lane_valid;

    // ========================================
    // branch resolve per lane.
    // ========================================
    always_comb begin : resolve
        alu_result_pkg::branch_flags_t f;
        f     = '0;
        taken = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            f = alu_result_pkg::branch_flags_t'(lane_flags[i*FW +: FW]);
            case (branch_kind)
                mips_isa_pkg::BR_EQ:  taken[i] = f.eq;
                mips_isa_pkg::BR_NE:  taken[i] = ~f.eq;
                mips_isa_pkg::BR_LEZ: taken[i] = f.neg | f.zero;
                mips_isa_pkg::BR_GTZ: taken[i] = f.pos;
                default:              taken[i] = 1'b0;
            endcase
        end
        // an illegal word contributes nothing.
        if (illegal_in) begin
            taken = '0;
        end
    end

    assign packed_word = illegal_in ? '0 : lane_word;

    // ========================================
    // output register.
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            result       <= '0;
            branch_taken <= '0;
            illegal      <= 1'b0;
        end else begin
            result_valid <= any_valid;
            illegal      <= any_valid & illegal_in;
            if (any_valid) begin
                result       <= packed_word;
                branch_taken <= taken;
            end
        end
    end

    // lanes share one valid from the decoder.
    a_lanes_aligned: assert property (@(posedge clk) disable iff (rst)
        (&lane_valid) == (|lane_valid))
        else $error("result_collect: lane valids split %b", lane_valid);

endmodule

// File: verilog/alu_lane.sv
`timescale 1ns/1ps

module alu_lane (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  mips_isa_pkg::opcode_t         opcode,
    input  mips_isa_pkg::funct_t          funct,
    input  alu_result_pkg::word_t         op1,
    input  alu_result_pkg::word_t         op2,
    output logic                          out_valid,
    output alu_result_pkg::word_t         out_word,
    output alu_result_pkg::branch_flags_t out_flags
);

    // combinational outputs of the shared alu.
    alu_result_pkg::word_t         alu_word;
    alu_result_pkg::branch_flags_t alu_flags;

    // ========================================
    // alu.
    // ========================================
    add_sub_logic u_alu (
        .opcode            (opcode),
        .funct             (funct),
        .op1               (op1),
        .op2               (op2),
        .add_sub_out       (alu_word),
        .branch_conditions (alu_flags)
    );

    // ========================================
    // lane register.
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_word  <= '0;
            out_flags <= '0;
        end else begin
            out_valid <= in_valid;
            // payload only moves with a valid instruction.
            if (in_valid) begin
                out_word  <= alu_word;
                out_flags <= alu_flags;
            end
        end
    end

    // the sign class is one-hot on every valid lane result.
    a_sign_onehot: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $onehot({out_flags.neg, out_flags.zero, out_flags.pos}))
        else $error("alu_lane: sign flags %b not one-hot", out_flags);

endmodule

// File: verilog/instr_decode.sv
`timescale 1ns/1ps
`include "mips_alu_consts.svh"

module instr_decode #(
    parameter int NUM_LANES = `ALU_NUM_LANES
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              instr_valid,
    input  logic [31:0]                       instr,
    input  logic [NUM_LANES*`ALU_WORD_W-1:0]  op_a,
    input  logic [NUM_LANES*`ALU_WORD_W-1:0]  op_b,
    output logic                              lane_valid,
    output mips_isa_pkg::opcode_t             opcode,
    output mips_isa_pkg::funct_t              funct,
    output logic [NUM_LANES*`ALU_WORD_W-1:0]  lane_op1,
    output logic [NUM_LANES*`ALU_WORD_W-1:0]  lane_op2,
    output mips_isa_pkg::branch_kind_t        branch_kind,
    output logic                              illegal
);

    localparam int W = `ALU_WORD_W;

    // instruction fields.
    mips_isa_pkg::opcode_t      opc;
    mips_isa_pkg::funct_t       fn;
    logic [`ALU_IMM_W-1:0]      imm;
    alu_result_pkg::word_t      imm_ext;
    // classification of the incoming word.
    logic                       is_alu;
    logic                       is_branch;
    logic                       is_illegal;
    logic                       use_imm;
    logic                       imm_signed;
    mips_isa_pkg::branch_kind_t kind;
    // side band after the first stage.
    mips_isa_pkg::branch_kind_t kind_q;
    logic                       illegal_q;

    assign opc = mips_isa_pkg::opcode_t'(instr[31:26]);
    assign fn  = mips_isa_pkg::funct_t'(instr[5:0]);
    assign imm = instr[`ALU_IMM_W-1:0];

    // arithmetic immediates sign extend, logical ones zero extend.
    assign imm_ext = imm_signed ? {{(W-`ALU_IMM_W){imm[`ALU_IMM_W-1]}}, imm}
                                : {{(W-`ALU_IMM_W){1'b0}}, imm};

    // ========================================
    // classify.
    // ========================================
    always_comb begin
        is_alu     = 1'b0;
        is_branch  = 1'b0;
        is_illegal = 1'b0;
        use_imm    = 1'b0;
        imm_signed = 1'b0;
        kind       = mips_isa_pkg::BR_NONE;
        case (opc)
            mips_isa_pkg::OP_SPECIAL: begin
                case (fn)
                    mips_isa_pkg::FN_ADDU, mips_isa_pkg::FN_SUBU, mips_isa_pkg::FN_AND,
                    mips_isa_pkg::FN_OR, mips_isa_pkg::FN_XOR: is_alu = 1'b1;
                    default: is_illegal = 1'b1;
                endcase
            end
            mips_isa_pkg::OP_ADDIU,
            mips_isa_pkg::OP_LB, mips_isa_pkg::OP_LH, mips_isa_pkg::OP_LWL,
            mips_isa_pkg::OP_LW, mips_isa_pkg::OP_LBU, mips_isa_pkg::OP_LHU,
            mips_isa_pkg::OP_LWR, mips_isa_pkg::OP_SB, mips_isa_pkg::OP_SH,
            mips_isa_pkg::OP_SW: begin
                is_alu     = 1'b1;
                use_imm    = 1'b1;
                imm_signed = 1'b1;
            end
            mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI: begin
                is_alu  = 1'b1;
                use_imm = 1'b1;
            end
            mips_isa_pkg::OP_BEQ: begin
                is_branch = 1'b1;
                kind      = mips_isa_pkg::BR_EQ;
            end
            mips_isa_pkg::OP_BNE: begin
                is_branch = 1'b1;
                kind      = mips_isa_pkg::BR_NE;
            end
            mips_isa_pkg::OP_BLEZ: begin
                is_branch = 1'b1;
                kind      = mips_isa_pkg::BR_LEZ;
            end
            mips_isa_pkg::OP_BGTZ: begin
                is_branch = 1'b1;
                kind      = mips_isa_pkg::BR_GTZ;
            end
            default: is_illegal = 1'b1;
        endcase
    end

    // ========================================
    // stage 1 and aligned side band.
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            lane_valid  <= 1'b0;
            opcode      <= mips_isa_pkg::OP_SPECIAL;
            funct       <= mips_isa_pkg::funct_t'('0);
            lane_op1    <= '0;
            lane_op2    <= '0;
            kind_q      <= mips_isa_pkg::BR_NONE;
            illegal_q   <= 1'b0;
            branch_kind <= mips_isa_pkg::BR_NONE;
            illegal     <= 1'b0;
        end else begin
            lane_valid <= instr_valid;
            kind_q     <= instr_valid ? kind : mips_isa_pkg::BR_NONE;
            illegal_q  <= instr_valid & is_illegal;
            if (instr_valid) begin
                opcode <= opc;
                funct  <= fn;
                // every lane gets its own pair, op2 may be the immediate.
                for (int i = 0; i < NUM_LANES; i++) begin
                    lane_op1[i*W +: W] <= op_a[i*W +: W];
                    lane_op2[i*W +: W] <= use_imm ? imm_ext : op_b[i*W +: W];
                end
            end
            // one more edge so these meet the lane registers.
            branch_kind <= kind_q;
            illegal     <= illegal_q;
        end
    end

    // each accepted word is alu work, a branch or illegal, never two.
    a_one_class: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> $onehot({is_alu, is_branch, is_illegal}))
        else $error("instr_decode: word %h not in exactly one class", instr);

endmodule

// File: verilog/add_sub_logic.sv
`timescale 1ns/1ps

module add_sub_logic (
    input  mips_isa_pkg::opcode_t         opcode,
    input  mips_isa_pkg::funct_t          funct,
    input  alu_result_pkg::word_t         op1,
    input  alu_result_pkg::word_t         op2,
    output alu_result_pkg::word_t         add_sub_out,
    output alu_result_pkg::branch_flags_t branch_conditions
);

    // all five results are formed every cycle.
    alu_result_pkg::word_t add_res;
    alu_result_pkg::word_t sub_res;
    alu_result_pkg::word_t and_res;
    alu_result_pkg::word_t or_res;
    alu_result_pkg::word_t xor_res;

    assign add_res = op1 + op2;
    assign sub_res = op1 - op2;
    assign and_res = op1 & op2;
    assign or_res  = op1 | op2;
    assign xor_res = op1 ^ op2;

    // ========================================
    // result select.
    // ========================================
    always_comb begin
        add_sub_out = '0;
        if (opcode == mips_isa_pkg::OP_SPECIAL) begin
            // r-type, funct picks the operation.
            case (funct)
                mips_isa_pkg::FN_ADDU: add_sub_out = add_res;
                mips_isa_pkg::FN_SUBU: add_sub_out = sub_res;
                mips_isa_pkg::FN_AND:  add_sub_out = and_res;
                mips_isa_pkg::FN_OR:   add_sub_out = or_res;
                mips_isa_pkg::FN_XOR:  add_sub_out = xor_res;
                default:               add_sub_out = '0;
            endcase
        end else begin
            case (opcode)
                // addiu plus every load and store address sum.
                mips_isa_pkg::OP_ADDIU,
                mips_isa_pkg::OP_LB, mips_isa_pkg::OP_LH,
                mips_isa_pkg::OP_LWL, mips_isa_pkg::OP_LW,
                mips_isa_pkg::OP_LBU, mips_isa_pkg::OP_LHU,
                mips_isa_pkg::OP_LWR, mips_isa_pkg::OP_SB,
                mips_isa_pkg::OP_SH, mips_isa_pkg::OP_SW: add_sub_out = add_res;
                mips_isa_pkg::OP_ANDI: add_sub_out = and_res;
                mips_isa_pkg::OP_ORI:  add_sub_out = or_res;
                mips_isa_pkg::OP_XORI: add_sub_out = xor_res;
                // branches and anything unknown give zero.
                default:               add_sub_out = '0;
            endcase
        end
    end

    // ========================================
    // branch flags.
    // ========================================
    always_comb begin
        branch_conditions = '0;
        // sign class of op1, exactly one of three.
        if ($signed(op1) < 0) begin
            branch_conditions.neg = 1'b1;
        end else if (op1 == '0) begin
            branch_conditions.zero = 1'b1;
        end else begin
            branch_conditions.pos = 1'b1;
        end
        branch_conditions.eq = (op1 == op2);
    end

endmodule

// File: verilog/alu_result_pkg.sv
`include "mips_alu_consts.svh"

package alu_result_pkg;

    // ========================================
    // result-side types.
    // ========================================

    // one data word of a lane.
    typedef logic [`ALU_WORD_W-1:0] word_t;

    // flags of one lane, msb first.
    // bit 3 eq, bit 2 pos, bit 1 zero, bit 0 neg.
    typedef struct packed {
        // op1 equals op2.
        logic eq;
        // op1 signed greater than zero.
        logic pos;
        // op1 is zero.
        logic zero;
        // op1 signed negative.
        logic neg;
    } branch_flags_t;

    // one bit per lane.
    typedef logic [`ALU_NUM_LANES-1:0] lane_mask_t;

endpackage

// File: verilog/mips_isa_pkg.sv
package mips_isa_pkg;

    // ========================================
    // primary opcode field, instr[31:26].
    // ========================================
    typedef enum logic [5:0] {
        // r-type, operation chosen by funct.
        OP_SPECIAL = 6'b000000,
        // conditional branches.
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        // immediate arithmetic and logic.
        OP_ADDIU   = 6'b001001,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        // loads, only the address sum is formed here.
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LWL     = 6'b100010,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_LWR     = 6'b100110,
        // stores, same treatment as loads.
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_t;

    // function field of special, instr[5:0].
    typedef enum logic [5:0] {
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110
    } funct_t;

    // branch condition the collector applies to the lane flags.
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LEZ  = 3'd3,
        BR_GTZ  = 3'd4
    } branch_kind_t;

endpackage

// File: verilog/mips_alu_consts.svh
`ifndef MIPS_ALU_CONSTS_SVH
`define MIPS_ALU_CONSTS_SVH

// ========================================
// cluster sizing.
// ========================================

// default number of identical alu lanes.
`define ALU_NUM_LANES 4

// width of one data word.
`define ALU_WORD_W 32

// width of the i-type immediate field.
`define ALU_IMM_W 16

// edges from an accepted instruction to its result strobe.
`define ALU_LATENCY 3

`endif
